//--- build.f
hw/fetch_pkg.sv
hw/redirect_capture.sv
hw/muldiv_hold.sv
hw/pc_sequencer.sv
hw/fetch_port.sv
hw/fetch_top.sv
testbench/tb_clock.sv
testbench/imem_model.sv
testbench/tb_fetch.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the fetch testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_fetch \
    -Mdir obj_dir -o tb_fetch_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^>>> PASS$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- testbench/tb_fetch.sv
`timescale 1ns/1ns

module tb_fetch;
    import fetch_pkg::*;

    localparam inst_t MASK = 32'h1357_9bdf;

    logic  clk, rst_n;
    logic  ar_hs, r_done, r_due, if_valid, inst_valid;
    logic  branch_taken, jalr, mem_stall, md_start, md_busy, md_done;
    addr_t branch_pc, jalr_pc, ar_addr, inst_pc;
    inst_t r_data, inst;

    logic       [2:0] test_id;
    addr_t      last_addr, last_branch_pc, last_jalr_pc, prev_inst_pc;
    logic       last_r_done, jalr_d, have_prev;
    logic       [1:0] md_track;
    int         errors = 0;
    int         tests = 0;

    tb_clock u_clk (.clk(clk), .rst_n(rst_n));

    imem_model u_mem (
        .clk(clk), .rst_n(rst_n), .if_valid(if_valid), .ar_addr(ar_addr),
        .ar_hs(ar_hs), .r_done(r_done), .r_data(r_data), .r_due(r_due)
    );

    fetch_top uut (
        .clk(clk), .rst_n(rst_n), .ar_hs(ar_hs), .r_done(r_done), .r_data(r_data),
        .branch_taken(branch_taken), .branch_pc(branch_pc), .jalr(jalr),
        .jalr_pc(jalr_pc), .mem_stall(mem_stall), .md_start(md_start),
        .md_busy(md_busy), .md_done(md_done), .if_valid(if_valid),
        .ar_addr(ar_addr), .inst(inst), .inst_pc(inst_pc), .inst_valid(inst_valid)
    );

    // Previous-cycle copies, and the expected multiply/divide hold state.
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_addr      <= '0;
            last_branch_pc <= '0;
            last_jalr_pc   <= '0;
            last_r_done    <= 1'b0;
            jalr_d         <= 1'b0;
            have_prev      <= 1'b0;
            prev_inst_pc   <= '0;
            md_track       <= 2'd0;
        end else begin
            last_addr      <= ar_addr;
            last_branch_pc <= branch_pc;
            last_jalr_pc   <= jalr_pc;
            last_r_done    <= r_done;
            jalr_d         <= jalr;
            if (test_id != 3'd2) begin
                have_prev <= 1'b0;
            end else if (inst_valid) begin
                have_prev    <= 1'b1;
                prev_inst_pc <= inst_pc;
            end
            case (md_track)
                2'd0: if (md_start) md_track <= 2'd1;
                2'd1: begin
                    if (md_done && r_done) begin
                        md_track <= 2'd3;
                    end else if (md_done) begin
                        md_track <= 2'd2;
                    end
                end
                2'd2: if (r_done) md_track <= 2'd3;
                default: md_track <= 2'd0;
            endcase
        end
    end

    a_inst_data: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid |-> inst == (inst_pc ^ MASK))
        else begin
            $display("Fail inst: got %h, expected %h", inst, inst_pc ^ MASK);
            errors++;
        end

    a_pc_step: assert property (@(posedge clk) disable iff (!rst_n)
        (test_id == 3'd2) && inst_valid && have_prev |-> inst_pc == prev_inst_pc + 32'd4)
        else begin
            $display("Fail inst_pc: got %h, expected %h", inst_pc, prev_inst_pc + 32'd4);
            errors++;
        end

    a_if_valid_low: assert property (@(posedge clk) disable iff (!rst_n)
        ar_hs || r_done |=> !if_valid)
        else begin
            $display("Fail if_valid: got %h, expected 0", if_valid);
            errors++;
        end

    a_if_valid_back: assert property (@(posedge clk) disable iff (!rst_n)
        r_done |-> ##2 if_valid)
        else begin
            $display("Fail if_valid: got %h, expected 1", if_valid);
            errors++;
        end

    a_branch_load: assert property (@(posedge clk) disable iff (!rst_n)
        branch_taken && (branch_pc != ar_addr + 32'd4) |=> ar_addr == last_branch_pc)
        else begin
            $display("Fail ar_addr: got %h, expected %h", ar_addr, last_branch_pc);
            errors++;
        end

    a_branch_seq: assert property (@(posedge clk) disable iff (!rst_n)
        branch_taken && (branch_pc == ar_addr + 32'd4)
        |=> ar_addr == (last_r_done ? last_addr + 32'd4 : last_addr))
        else begin
            $display("Fail ar_addr: got %h, expected %h", ar_addr,
                     last_r_done ? last_addr + 32'd4 : last_addr);
            errors++;
        end

    a_jalr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        jalr |=> ar_addr == last_addr)
        else begin
            $display("Fail ar_addr: got %h, expected %h", ar_addr, last_addr);
            errors++;
        end

    a_jalr_load: assert property (@(posedge clk) disable iff (!rst_n)
        jalr_d |=> ar_addr == last_jalr_pc)
        else begin
            $display("Fail ar_addr: got %h, expected %h", ar_addr, last_jalr_pc);
            errors++;
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_stall |=> ar_addr == last_addr)
        else begin
            $display("Fail ar_addr: got %h, expected %h", ar_addr, last_addr);
            errors++;
        end

    a_md_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (md_track == 2'd1) || (md_track == 2'd2) |=> ar_addr == last_addr)
        else begin
            $display("Fail ar_addr: got %h, expected %h", ar_addr, last_addr);
            errors++;
        end

    a_md_release: assert property (@(posedge clk) disable iff (!rst_n)
        md_track == 2'd3 |=> ar_addr == last_addr + 32'd4)
        else begin
            $display("Fail ar_addr: got %h, expected %h", ar_addr, last_addr + 32'd4);
            errors++;
        end

    function automatic logic cond_met(input int kind);
        case (kind)
            0:       return inst_valid;
            1:       return if_valid && !ar_hs;
            2:       return r_due;
            3:       return !r_done;
            default: return rst_n;
        endcase
    endfunction

    // Waits on rising edges until the condition holds, for at most 64 cycles.
    task automatic wait_until(input int kind, input string what);
        int   n;
        logic met;
        n   = 0;
        met = 1'b0;
        while (!met && n < 64) begin
            @(posedge clk);
            met = cond_met(kind);
            n++;
        end
        if (!met) begin
            $display("Timeout while waiting for %s", what);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        repeat (3) @(posedge clk);
        tests++;
        if (errors == errs_before) begin
            $display("Test %0d %s: ok", tests, name);
        end else begin
            $display("Test %0d %s: %0d errors", tests, name, errors - errs_before);
        end
    endtask

    initial begin
        int e;
        branch_taken = 1'b0;
        branch_pc    = '0;
        jalr         = 1'b0;
        jalr_pc      = '0;
        mem_stall    = 1'b0;
        md_start     = 1'b0;
        md_busy      = 1'b0;
        md_done      = 1'b0;
        test_id      = 3'd0;

        wait_until(4, "reset release");
        e = errors;
        a_reset_pc: assert (ar_addr == 32'h8000_0000)
            else begin
                $display("Fail ar_addr: got %h, expected 80000000", ar_addr);
                errors++;
            end
        a_reset_valid: assert (inst_valid == 1'b0)
            else begin
                $display("Fail inst_valid: got %h, expected 0", inst_valid);
                errors++;
            end
        a_reset_if_valid: assert (if_valid == 1'b0)
            else begin
                $display("Fail if_valid: got %h, expected 0", if_valid);
                errors++;
            end
        finish_test("reset state", e);

        e = errors;
        test_id <= 3'd2;
        repeat (8) wait_until(0, "inst_valid in sequential fetch");
        test_id <= 3'd0;
        finish_test("sequential fetch", e);

        e = errors;
        branch_taken <= 1'b1;
        branch_pc    <= 32'h8000_0200;
        @(posedge clk);
        branch_taken <= 1'b0;
        repeat (2) wait_until(0, "inst_valid after branch");
        // Target equal to PC+4 at an edge where the PC does not move.
        wait_until(3, "a cycle without r_done");
        branch_taken <= 1'b1;
        branch_pc    <= ar_addr + 32'd4;
        @(posedge clk);
        branch_taken <= 1'b0;
        repeat (2) wait_until(0, "inst_valid after sequential branch");
        finish_test("branch", e);

        e = errors;
        jalr <= 1'b1;
        @(posedge clk);
        jalr    <= 1'b0;
        jalr_pc <= 32'h8000_0400;
        @(posedge clk);
        repeat (2) wait_until(0, "inst_valid after jalr");
        finish_test("jalr", e);

        e = errors;
        mem_stall <= 1'b1;
        repeat (12) @(posedge clk);
        mem_stall <= 1'b0;
        repeat (2) wait_until(0, "inst_valid after stall");
        finish_test("memory stall", e);

        e = errors;
        md_start <= 1'b1;
        md_busy  <= 1'b1;
        @(posedge clk);
        md_start <= 1'b0;
        wait_until(2, "r_done due for md_done alignment");
        md_done <= 1'b1;
        @(posedge clk);
        md_done <= 1'b0;
        md_busy <= 1'b0;
        repeat (2) wait_until(0, "inst_valid after muldiv");
        finish_test("muldiv with r_done", e);

        e = errors;
        md_start <= 1'b1;
        md_busy  <= 1'b1;
        @(posedge clk);
        md_start <= 1'b0;
        wait_until(1, "idle fetch before md_done");
        md_done <= 1'b1;
        @(posedge clk);
        md_done <= 1'b0;
        md_busy <= 1'b0;
        repeat (2) wait_until(0, "inst_valid after early md_done");
        finish_test("muldiv before r_done", e);

        $display("Tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- testbench/imem_model.sv
`timescale 1ns/1ns

module imem_model (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             if_valid,
    input  fetch_pkg::addr_t ar_addr,
    output logic             ar_hs,
    output logic             r_done,
    output fetch_pkg::inst_t r_data,
    output logic             r_due
);

    integer     seed;
    logic       busy;
    logic [2:0] cnt;

    initial seed = 32'hfd47_1750;

    // Read data follows the address the DUT presents.
    assign r_data = ar_addr ^ 32'h1357_9bdf;
    // High in the cycle before r_done rises.
    assign r_due  = busy && (cnt == 3'd1);

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_hs  <= 1'b0;
            r_done <= 1'b0;
            busy   <= 1'b0;
            cnt    <= 3'd0;
        end else begin
            ar_hs  <= 1'b0;
            r_done <= 1'b0;
            if (!busy && if_valid && !ar_hs) begin
                ar_hs <= 1'b1;
                busy  <= 1'b1;
                cnt   <= 3'd1 + 3'($unsigned($random(seed)) % 4);
            end else if (busy) begin
                if (cnt == 3'd1) begin
                    r_done <= 1'b1;
                    busy   <= 1'b0;
                end else begin
                    cnt <= cnt - 3'd1;
                end
            end
        end
    end

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 8 ns period.
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- hw/fetch_top.sv
`timescale 1ns/1ns

module fetch_top #(
    parameter fetch_pkg::addr_t RESET_PC = 32'h8000_0000
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             ar_hs,
    input  logic             r_done,
    input  fetch_pkg::inst_t r_data,
    input  logic             branch_taken,
    input  fetch_pkg::addr_t branch_pc,
    input  logic             jalr,
    input  fetch_pkg::addr_t jalr_pc,
    input  logic             mem_stall,
    input  logic             md_start,
    input  logic             md_busy,
    input  logic             md_done,
    output logic             if_valid,
    output fetch_pkg::addr_t ar_addr,
    output fetch_pkg::inst_t inst,
    output fetch_pkg::addr_t inst_pc,
    output logic             inst_valid
);
    import fetch_pkg::*;

    redirect_t redirect;
    addr_t     curr_pc;
    logic      md_hold;
    logic      md_release;

    redirect_capture u_redirect (
        .clk          (clk),
        .rst_n        (rst_n),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc),
        .jalr         (jalr),
        .jalr_pc      (jalr_pc),
        .mem_stall    (mem_stall),
        .curr_pc      (curr_pc),
        .redirect     (redirect)
    );

    muldiv_hold u_muldiv (
        .clk        (clk),
        .rst_n      (rst_n),
        .md_start   (md_start),
        .md_busy    (md_busy),
        .md_done    (md_done),
        .r_done     (r_done),
        .md_hold    (md_hold),
        .md_release (md_release)
    );

    pc_sequencer #(
        .RESET_PC (RESET_PC)
    ) u_pc (
        .clk        (clk),
        .rst_n      (rst_n),
        .ar_hs      (ar_hs),
        .r_done     (r_done),
        .redirect   (redirect),
        .md_hold    (md_hold),
        .md_release (md_release),
        .curr_pc    (curr_pc),
        .if_valid   (if_valid)
    );

    fetch_port u_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .curr_pc    (curr_pc),
        .r_done     (r_done),
        .r_data     (r_data),
        .ar_addr    (ar_addr),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .inst_valid (inst_valid)
    );

endmodule

//--- hw/fetch_port.sv
`timescale 1ns/1ns

module fetch_port (
    input  logic             clk,
    input  logic             rst_n,
    input  fetch_pkg::addr_t curr_pc,
    input  logic             r_done,
    input  fetch_pkg::inst_t r_data,
    output fetch_pkg::addr_t ar_addr,
    output fetch_pkg::inst_t inst,
    output fetch_pkg::addr_t inst_pc,
    output logic             inst_valid
);

    assign ar_addr = curr_pc;

    // The PC still points at this fetch when r_done is sampled.
    always_ff @(posedge clk) begin
        if (r_done) begin
            inst    <= r_data;
            inst_pc <= curr_pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= r_done;
        end
    end

endmodule

//--- hw/pc_sequencer.sv
`timescale 1ns/1ns

module pc_sequencer #(
    parameter fetch_pkg::addr_t RESET_PC = 32'h8000_0000
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ar_hs,
    input  logic                 r_done,
    input  fetch_pkg::redirect_t redirect,
    input  logic                 md_hold,
    input  logic                 md_release,
    output fetch_pkg::addr_t     curr_pc,
    output logic                 if_valid
);
    import fetch_pkg::*;

    fetch_state_t state;
    fetch_state_t next_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= f_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            f_idle: begin
                if (ar_hs) begin
                    next_state = f_wait;
                end
            end
            f_wait: begin
                if (r_done) begin
                    next_state = f_finish;
                end
            end
            f_finish: next_state = f_idle;
            default:  next_state = f_idle;
        endcase
    end

    // A new request is offered only once the state machine is back in idle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_valid <= 1'b0;
        end else begin
            if_valid <= (next_state == f_idle);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curr_pc <= RESET_PC;
        end else if (md_release) begin
            curr_pc <= curr_pc + 32'd4;
        end else if (md_hold) begin
            curr_pc <= curr_pc;
        end else if (redirect.hold) begin
            curr_pc <= curr_pc;
        end else if (redirect.load) begin
            curr_pc <= redirect.target;
        end else if (r_done && redirect.advance_ok) begin
            curr_pc <= curr_pc + 32'd4;
        end
    end

    // Only one request may be in flight.
    a_hs_in_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        ar_hs |-> (state == f_idle)
    );

endmodule

//--- hw/muldiv_hold.sv
`timescale 1ns/1ns

module muldiv_hold (
    input  logic clk,
    input  logic rst_n,
    input  logic md_start,
    input  logic md_busy,
    input  logic md_done,
    input  logic r_done,
    output logic md_hold,
    output logic md_release
);
    import fetch_pkg::*;

    md_state_t state;
    md_state_t next_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= md_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            md_idle: begin
                if (md_start) begin
                    next_state = md_arith;
                end
            end
            md_arith: begin
                // The fetch may finish in the same cycle as the arithmetic.
                if (md_done && r_done) begin
                    next_state = md_end;
                end else if (md_done) begin
                    next_state = md_after;
                end
            end
            md_after: begin
                if (r_done) begin
                    next_state = md_end;
                end
            end
            md_end:  next_state = md_idle;
            default: next_state = md_idle;
        endcase
    end

    assign md_hold    = (state == md_arith) || (state == md_after);
    assign md_release = (state == md_end);

    a_done_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        md_done |-> md_busy
    );

endmodule

//--- hw/redirect_capture.sv
`timescale 1ns/1ns

module redirect_capture (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 branch_taken,
    input  fetch_pkg::addr_t     branch_pc,
    input  logic                 jalr,
    input  fetch_pkg::addr_t     jalr_pc,
    input  logic                 mem_stall,
    input  fetch_pkg::addr_t     curr_pc,
    output fetch_pkg::redirect_t redirect
);
    import fetch_pkg::*;

    logic  jalr_d;
    logic  branch_redirect;
    addr_t seq_pc;

    // The jump target arrives one cycle after the jalr pulse.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jalr_d <= 1'b0;
        end else begin
            jalr_d <= jalr;
        end
    end

    assign seq_pc          = curr_pc + 32'd4;
    assign branch_redirect = branch_taken && (branch_pc != seq_pc);

    // Stall first, then the jump hold, the jump load, the branch load.
    always_comb begin
        redirect.hold       = mem_stall || jalr;
        redirect.load       = !redirect.hold && (jalr_d || branch_redirect);
        redirect.target     = jalr_d ? jalr_pc : branch_pc;
        redirect.advance_ok = !(mem_stall || jalr || jalr_d || branch_redirect);
    end

    // A jump request is a single-cycle pulse.
    a_jalr_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        jalr |=> !jalr
    );

endmodule

//--- hw/fetch_pkg.sv
package fetch_pkg;

    // Instruction address and instruction word.
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // Fetch request sequencing.
    typedef enum logic [1:0] {
        f_idle,
        f_wait,
        f_finish
    } fetch_state_t;

    // Tracks a multiply or divide against fetch completion.
    typedef enum logic [1:0] {
        md_idle,
        md_arith,
        md_after,
        md_end
    } md_state_t;

    // Merged redirect request seen by the PC register.
    typedef struct packed {
        logic  hold;
        logic  load;
        addr_t target;
        logic  advance_ok;
    } redirect_t;

endpackage
